/* ppu_line.f */
ppu_pkg.sv
vram_bus_if.sv
vram.sv
vram_arbiter.sv
bg_fetcher.sv
sprite_fetcher.sv
sprite_pixel_shifter.sv
pixel_mixer.sv
ppu_line.sv
ppu_line_chk.sv
ppu_line_tb.sv

/* ppu_line_tb.sv */
module ppu_line_tb;

	localparam int LINE_PIXELS = 32;
	localparam int GROUPS = LINE_PIXELS / 8;
	localparam int NUM_TESTS = 9;
	localparam int TILES = 7;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLE_LIMIT = NUM_TESTS * 400 + RESET_CYCLES + TILES * 16 + GROUPS + 20;

	logic clkpipe;
	logic arst_n;
	logic vram_we;
	ppu_pkg::vram_addr_t vram_waddr;
	ppu_pkg::vram_data_t vram_wdata;
	logic line_start;
	logic [2:0] line_row;
	logic spr_valid;
	logic [7:0] spr_x;
	logic [7:0] spr_tile;
	logic [2:0] spr_row;
	logic spr_xflip;
	logic pix_ready;
	logic spr_ready;
	logic pix_valid;
	logic [1:0] pix_color;
	logic line_busy;

	integer seed;
	int cycles;
	int errors;
	int tests_ok;

	// one table entry per line; a stall entry repeats the line before it.
	logic [2:0] t_row [NUM_TESTS];
	int t_nspr [NUM_TESTS];
	logic t_stall [NUM_TESTS];
	ppu_pkg::spr_entry_t t_spr [NUM_TESTS][4];

	ppu_pkg::vram_data_t tile_img [TILES * 16];
	ppu_pkg::vram_data_t map_img [GROUPS];
	logic [1:0] exp_color [LINE_PIXELS];
	logic [1:0] got_color [LINE_PIXELS];
	logic [1:0] prev_color [LINE_PIXELS];

	ppu_line #(
		.LINE_PIXELS (LINE_PIXELS)
	) dut_i (
		.clkpipe    (clkpipe),
		.arst_n     (arst_n),
		.vram_we    (vram_we),
		.vram_waddr (vram_waddr),
		.vram_wdata (vram_wdata),
		.line_start (line_start),
		.line_row   (line_row),
		.spr_valid  (spr_valid),
		.spr_x      (spr_x),
		.spr_tile   (spr_tile),
		.spr_row    (spr_row),
		.spr_xflip  (spr_xflip),
		.pix_ready  (pix_ready),
		.spr_ready  (spr_ready),
		.pix_valid  (pix_valid),
		.pix_color  (pix_color),
		.line_busy  (line_busy)
	);

	initial begin
		clkpipe = 1'b0;
		forever #2 clkpipe = ~clkpipe;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clkpipe);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("tests failed");
		$finish;
	end

	task automatic set_test(input int idx, input logic [2:0] row, input int nspr, input logic stall);
		t_row[idx] = row;
		t_nspr[idx] = nspr;
		t_stall[idx] = stall;
	endtask

	task automatic set_sprite(input int idx, input int k, input logic [7:0] sx,
		input logic [7:0] st, input logic [2:0] sr, input logic sf);
		t_spr[idx][k] = '{x: sx, tile: st, row: sr, xflip: sf};
	endtask

	task automatic load_table;
		set_test(0, 3'd0, 0, 1'b0);
		set_test(1, 3'd3, 0, 1'b0);
		set_test(2, 3'd2, 1, 1'b0);
		set_sprite(2, 0, 8'd5, 8'd1, 3'd4, 1'b0);
		set_test(3, 3'd2, 1, 1'b0);
		set_sprite(3, 0, 8'd5, 8'd1, 3'd4, 1'b1);
		set_test(4, 3'd5, 2, 1'b0);
		set_sprite(4, 0, 8'd8, 8'd2, 3'd1, 1'b0);
		set_sprite(4, 1, 8'd9, 8'd3, 3'd6, 1'b1);
		set_test(5, 3'd1, 3, 1'b0);
		set_sprite(5, 0, 8'd16, 8'd0, 3'd2, 1'b0);
		set_sprite(5, 1, 8'd16, 8'd3, 3'd5, 1'b1);
		set_sprite(5, 2, 8'd16, 8'd2, 3'd7, 1'b0);
		// the second sprite lies past the line and is never drawn.
		set_test(6, 3'd6, 2, 1'b0);
		set_sprite(6, 0, 8'd28, 8'd1, 3'd3, 1'b0);
		set_sprite(6, 1, 8'd40, 8'd2, 3'd0, 1'b0);
		set_test(7, 3'd4, 4, 1'b0);
		set_sprite(7, 0, 8'd0, 8'd4, 3'd2, 1'b0);
		set_sprite(7, 1, 8'd6, 8'd5, 3'd7, 1'b1);
		set_sprite(7, 2, 8'd9, 8'd6, 3'd0, 1'b0);
		set_sprite(7, 3, 8'd27, 8'd4, 3'd5, 1'b1);
		set_test(8, 3'd4, 4, 1'b1);
		for (int k = 0; k < 4; k++) begin
			t_spr[8][k] = t_spr[7][k];
		end
	endtask

	task automatic write_vram(input ppu_pkg::vram_addr_t addr, input ppu_pkg::vram_data_t data);
		@(posedge clkpipe);
		vram_we <= 1'b1;
		vram_waddr <= addr;
		vram_wdata <= data;
	endtask

	task automatic preload_vram;
		ppu_pkg::vram_addr_t a;
		int i;
		// tiles 0 to 3 get a fixed pattern; bits 6 and 0 of both planes stay clear.
		for (i = 0; i < TILES * 16; i++) begin
			a = ppu_pkg::vram_addr_t'(i);
			if (i < 64) begin
				tile_img[i] = 8'(a * 29 + (a >> 3)) & (a[0] ? 8'h9e : 8'hb6);
			end else begin
				tile_img[i] = 8'($random(seed));
			end
			write_vram(a, tile_img[i]);
		end
		for (i = 0; i < GROUPS; i++) begin
			map_img[i] = 8'((GROUPS - 1 - i) % 4);
			write_vram(ppu_pkg::MAP_BASE + ppu_pkg::vram_addr_t'(i), map_img[i]);
		end
		@(posedge clkpipe);
		vram_we <= 1'b0;
	endtask

	task automatic build_expected(input int idx);
		logic [1:0] spr_col [LINE_PIXELS];
		ppu_pkg::vram_data_t lo;
		ppu_pkg::vram_data_t hi;
		logic [1:0] c;
		int base;
		int px;
		int b;
		for (int p = 0; p < LINE_PIXELS; p++) begin
			spr_col[p] = 2'b00;
		end
		// sprites in arrival order, each filling only pixels still transparent.
		for (int k = 0; k < t_nspr[idx]; k++) begin
			base = t_spr[idx][k].tile * ppu_pkg::TILE_BYTES + 2 * t_spr[idx][k].row;
			lo = tile_img[base];
			hi = tile_img[base + 1];
			for (int i = 0; i < 8; i++) begin
				px = t_spr[idx][k].x + i;
				b = t_spr[idx][k].xflip ? i : 7 - i;
				c = {hi[b], lo[b]};
				if (px < LINE_PIXELS && spr_col[px] == 2'b00) begin
					spr_col[px] = c;
				end
			end
		end
		for (int p = 0; p < LINE_PIXELS; p++) begin
			base = map_img[p / 8] * ppu_pkg::TILE_BYTES + 2 * t_row[idx];
			lo = tile_img[base];
			hi = tile_img[base + 1];
			c = {hi[7 - p % 8], lo[7 - p % 8]};
			exp_color[p] = (spr_col[p] != 2'b00) ? spr_col[p] : c;
		end
	endtask

	task automatic feed_sprites(input int idx);
		for (int k = 0; k < t_nspr[idx]; k++) begin
			spr_x <= t_spr[idx][k].x;
			spr_tile <= t_spr[idx][k].tile;
			spr_row <= t_spr[idx][k].row;
			spr_xflip <= t_spr[idx][k].xflip;
			spr_valid <= 1'b1;
			@(posedge clkpipe);
			while (!spr_ready) begin
				@(posedge clkpipe);
			end
		end
		spr_valid <= 1'b0;
	endtask

	task automatic collect_pixels(input int idx, output int n, output int errs);
		n = 0;
		errs = 0;
		do begin
			@(posedge clkpipe);
			if (pix_valid && pix_ready) begin
				if (n >= LINE_PIXELS) begin
					$display("test %0d: extra pixel offered past the line end at %0t", idx, $time);
					errs++;
				end else begin
					got_color[n] = pix_color;
					if (pix_color !== exp_color[n]) begin
						$display("ERR %0t pix_color pixel %0d expected %0d actual %0d",
							$time, n, exp_color[n], pix_color);
						errs++;
					end
				end
				n++;
			end
			pix_ready <= t_stall[idx] ? 1'($random(seed)) : 1'b1;
		end while (line_busy);
	endtask

	task automatic run_line(input int idx);
		int n;
		int errs;
		build_expected(idx);
		@(posedge clkpipe);
		line_row <= t_row[idx];
		line_start <= 1'b1;
		pix_ready <= 1'b1;
		@(posedge clkpipe);
		line_start <= 1'b0;
		fork
			feed_sprites(idx);
			collect_pixels(idx, n, errs);
		join
		repeat (4) begin
			@(posedge clkpipe);
			if (pix_valid) begin
				$display("test %0d: pix_valid high after line_busy fell", idx);
				errs++;
			end
		end
		if (n != LINE_PIXELS) begin
			$display("test %0d: %0d pixels came out instead of %0d", idx, n, LINE_PIXELS);
			errs++;
		end
		for (int i = 0; i < LINE_PIXELS; i++) begin
			if (t_stall[idx] && got_color[i] !== prev_color[i]) begin
				$display("ERR %0t pix_color pixel %0d unstalled %0d stalled %0d",
					$time, i, prev_color[i], got_color[i]);
				errs++;
			end
			prev_color[i] = got_color[i];
		end
		errors += errs;
		if (errs == 0) begin
			tests_ok++;
		end
		$display("test %0d: %s, %0d pixels, %0d sprites, %0d errors",
			idx, (errs == 0) ? "ok" : "mismatch", n, t_nspr[idx], errs);
	endtask

	initial begin
		seed = 22401;
		errors = 0;
		tests_ok = 0;
		arst_n = 1'b0;
		vram_we = 1'b0;
		vram_waddr = '0;
		vram_wdata = '0;
		line_start = 1'b0;
		line_row = '0;
		spr_valid = 1'b0;
		spr_x = '0;
		spr_tile = '0;
		spr_row = '0;
		spr_xflip = 1'b0;
		pix_ready = 1'b0;
		repeat (RESET_CYCLES) @(posedge clkpipe);
		arst_n <= 1'b1;
		load_table();
		preload_vram();
		for (int idx = 0; idx < NUM_TESTS; idx++) begin
			run_line(idx);
		end
		$display("%0d of %0d tests ok, %0d errors", tests_ok, NUM_TESTS, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* ppu_line_chk.sv */
module ppu_line_chk (
	input logic clkpipe,
	input logic arst_n,
	input logic pix_valid,
	input logic pix_ready,
	input logic [1:0] pix_color,
	input logic spr_ready,
	input logic spr_rvalid,
	input logic bg_rvalid
);

	// a pixel that is not taken stays offered and unchanged.
	assert property (@(posedge clkpipe) disable iff (!arst_n)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_color))
		else $error("pix_color moved while pix_ready was low");

	// the arbiter returns at most one read per cycle.
	assert property (@(posedge clkpipe) disable iff (!arst_n) !(spr_rvalid && bg_rvalid))
		else $error("rvalid high on both VRAM buses in one cycle");

	// no sprite is taken before the first line starts.
	assert property (@(posedge clkpipe) $rose(arst_n) |-> !spr_ready)
		else $error("spr_ready high right after reset");

endmodule

bind ppu_line ppu_line_chk chk_i (
	.clkpipe    (clkpipe),
	.arst_n     (arst_n),
	.pix_valid  (pix_valid),
	.pix_ready  (pix_ready),
	.pix_color  (pix_color),
	.spr_ready  (spr_ready),
	.spr_rvalid (spr_bus.rvalid),
	.bg_rvalid  (bg_bus.rvalid)
);

/* ppu_line.sv */
module ppu_line #(
	parameter int LINE_PIXELS = 160
) (
	input logic clkpipe,
	input logic arst_n,
	input logic vram_we,
	input ppu_pkg::vram_addr_t vram_waddr,
	input ppu_pkg::vram_data_t vram_wdata,
	input logic line_start,
	input logic [2:0] line_row,
	input logic spr_valid,
	input logic [7:0] spr_x,
	input logic [7:0] spr_tile,
	input logic [2:0] spr_row,
	input logic spr_xflip,
	input logic pix_ready,
	output logic spr_ready,
	output logic pix_valid,
	output logic [1:0] pix_color,
	output logic line_busy
);

	ppu_pkg::vram_addr_t raddr;
	ppu_pkg::vram_data_t rdata;
	ppu_pkg::spr_entry_t spr_entry;
	ppu_pkg::vram_data_t bg_lo;
	ppu_pkg::vram_data_t bg_hi;
	ppu_pkg::vram_data_t spr_lo;
	ppu_pkg::vram_data_t spr_hi;
	logic fetch_req;
	logic bg_done;
	logic spr_go;
	logic spr_pending;
	logic [7:0] head_x;
	logic fetched_xflip;
	logic spr_load;
	logic spr_done;
	logic spr_shift;
	logic spr_pix_lo;
	logic spr_pix_hi;

	vram_bus_if bg_bus ();
	vram_bus_if spr_bus ();

	assign spr_entry = '{x: spr_x, tile: spr_tile, row: spr_row, xflip: spr_xflip};

	vram u_vram (
		.clkpipe (clkpipe),
		.we      (vram_we),
		.waddr   (vram_waddr),
		.wdata   (vram_wdata),
		.raddr   (raddr),
		.rdata   (rdata)
	);

	vram_arbiter u_arbiter (
		.clkpipe (clkpipe),
		.arst_n  (arst_n),
		.spr_bus (spr_bus),
		.bg_bus  (bg_bus),
		.raddr   (raddr),
		.rdata   (rdata)
	);

	bg_fetcher #(
		.LINE_PIXELS (LINE_PIXELS)
	) u_bg_fetcher (
		.clkpipe    (clkpipe),
		.arst_n     (arst_n),
		.fetch_req  (fetch_req),
		.line_row   (line_row),
		.line_start (line_start),
		.bus        (bg_bus),
		.bg_lo      (bg_lo),
		.bg_hi      (bg_hi),
		.bg_done    (bg_done)
	);

	sprite_fetcher u_sprite_fetcher (
		.clkpipe     (clkpipe),
		.arst_n      (arst_n),
		.spr_valid   (spr_valid),
		.spr_entry   (spr_entry),
		.spr_go      (spr_go),
		.line_start  (line_start),
		.spr_ready   (spr_ready),
		.spr_pending (spr_pending),
		.head_x      (head_x),
		.bus         (spr_bus),
		.spr_lo      (spr_lo),
		.spr_hi      (spr_hi),
		.spr_xflip   (fetched_xflip),
		.spr_load    (spr_load),
		.spr_done    (spr_done)
	);

	sprite_pixel_shifter u_sprite_shifter (
		.clkpipe    (clkpipe),
		.arst_n     (arst_n),
		.line_start (line_start),
		.spr_lo     (spr_lo),
		.spr_hi     (spr_hi),
		.spr_xflip  (fetched_xflip),
		.spr_load   (spr_load),
		.spr_shift  (spr_shift),
		.pix_lo     (spr_pix_lo),
		.pix_hi     (spr_pix_hi)
	);

	pixel_mixer #(
		.LINE_PIXELS (LINE_PIXELS)
	) u_pixel_mixer (
		.clkpipe     (clkpipe),
		.arst_n      (arst_n),
		.line_start  (line_start),
		.bg_lo       (bg_lo),
		.bg_hi       (bg_hi),
		.bg_done     (bg_done),
		.spr_pending (spr_pending),
		.head_x      (head_x),
		.spr_done    (spr_done),
		.spr_pix_lo  (spr_pix_lo),
		.spr_pix_hi  (spr_pix_hi),
		.pix_ready   (pix_ready),
		.fetch_req   (fetch_req),
		.spr_go      (spr_go),
		.spr_shift   (spr_shift),
		.pix_valid   (pix_valid),
		.pix_color   (pix_color),
		.line_busy   (line_busy)
	);

endmodule

/* pixel_mixer.sv */
module pixel_mixer #(
	parameter int LINE_PIXELS = 160
) (
	input logic clkpipe,
	input logic arst_n,
	input logic line_start,
	input ppu_pkg::vram_data_t bg_lo,
	input ppu_pkg::vram_data_t bg_hi,
	input logic bg_done,
	input logic spr_pending,
	input logic [7:0] head_x,
	input logic spr_done,
	input logic spr_pix_lo,
	input logic spr_pix_hi,
	input logic pix_ready,
	output logic fetch_req,
	output logic spr_go,
	output logic spr_shift,
	output logic pix_valid,
	output logic [1:0] pix_color,
	output logic line_busy
);

	logic [7:0] x;
	ppu_pkg::vram_data_t bg_lo_sr;
	ppu_pkg::vram_data_t bg_hi_sr;
	logic bg_ok;
	logic bg_wait;
	logic spr_wait;
	logic stall;
	logic accept;
	logic spr_hit;
	logic last_pix;
	logic [1:0] bg_color;
	logic [1:0] spr_color;

	assign stall = pix_valid && !pix_ready;
	assign accept = pix_valid && pix_ready;
	assign spr_hit = spr_pending && (head_x == x);
	assign last_pix = (x == 8'(LINE_PIXELS - 1));

	assign fetch_req = line_busy && !bg_ok && !bg_wait && !stall;
	// a sprite is only fetched while no pixel is offered, so pix_color cannot move.
	assign spr_go = line_busy && spr_hit && !spr_wait && !pix_valid;
	assign spr_shift = accept;

	assign bg_color = {bg_hi_sr[7], bg_lo_sr[7]};
	assign spr_color = {spr_pix_hi, spr_pix_lo};
	assign pix_color = (spr_color != 2'b00) ? spr_color : bg_color;

	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			line_busy <= 1'b0;
			x <= '0;
			bg_ok <= 1'b0;
			bg_wait <= 1'b0;
			spr_wait <= 1'b0;
			pix_valid <= 1'b0;
		end else if (line_start) begin
			line_busy <= 1'b1;
			x <= '0;
			bg_ok <= 1'b0;
			bg_wait <= 1'b0;
			spr_wait <= 1'b0;
			pix_valid <= 1'b0;
		end else begin
			if (fetch_req) begin
				bg_wait <= 1'b1;
			end
			if (bg_done) begin
				bg_wait <= 1'b0;
				bg_ok <= 1'b1;
			end
			if (spr_go) begin
				spr_wait <= 1'b1;
			end
			if (spr_done) begin
				spr_wait <= 1'b0;
			end
			if (accept) begin
				pix_valid <= 1'b0;
				x <= x + 1'b1;
				if (x[2:0] == 3'd7) begin
					bg_ok <= 1'b0;
				end
				if (last_pix) begin
					line_busy <= 1'b0;
				end
			end else if (line_busy && bg_ok && !spr_wait && !spr_hit) begin
				pix_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clkpipe) begin
		if (bg_done) begin
			bg_lo_sr <= bg_lo;
			bg_hi_sr <= bg_hi;
		end else if (accept) begin
			bg_lo_sr <= {bg_lo_sr[6:0], 1'b0};
			bg_hi_sr <= {bg_hi_sr[6:0], 1'b0};
		end
	end

endmodule

/* sprite_pixel_shifter.sv */
module sprite_pixel_shifter (
	input logic clkpipe,
	input logic arst_n,
	input logic line_start,
	input ppu_pkg::vram_data_t spr_lo,
	input ppu_pkg::vram_data_t spr_hi,
	input logic spr_xflip,
	input logic spr_load,
	input logic spr_shift,
	output logic pix_lo,
	output logic pix_hi
);

	ppu_pkg::vram_data_t lo_rev;
	ppu_pkg::vram_data_t hi_rev;
	ppu_pkg::vram_data_t lo_in;
	ppu_pkg::vram_data_t hi_in;
	ppu_pkg::vram_data_t open_slots;
	ppu_pkg::vram_data_t lo_sr;
	ppu_pkg::vram_data_t hi_sr;

	// bit 7 is the leftmost pixel, so a flip is a plain bit reversal.
	assign lo_rev = {<<{spr_lo}};
	assign hi_rev = {<<{spr_hi}};
	assign lo_in = spr_xflip ? lo_rev : spr_lo;
	assign hi_in = spr_xflip ? hi_rev : spr_hi;

	// a slot is free while its colour is zero; older sprites keep what they own.
	assign open_slots = ~(lo_sr | hi_sr);

	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			lo_sr <= '0;
			hi_sr <= '0;
		end else if (line_start) begin
			lo_sr <= '0;
			hi_sr <= '0;
		end else if (spr_load) begin
			lo_sr <= lo_sr | (lo_in & open_slots);
			hi_sr <= hi_sr | (hi_in & open_slots);
		end else if (spr_shift) begin
			lo_sr <= {lo_sr[6:0], 1'b0};
			hi_sr <= {hi_sr[6:0], 1'b0};
		end
	end

	assign pix_lo = lo_sr[7];
	assign pix_hi = hi_sr[7];

endmodule

/* sprite_fetcher.sv */
module sprite_fetcher (
	input logic clkpipe,
	input logic arst_n,
	input logic spr_valid,
	input ppu_pkg::spr_entry_t spr_entry,
	input logic spr_go,
	input logic line_start,
	output logic spr_ready,
	output logic spr_pending,
	output logic [7:0] head_x,
	vram_bus_if.requester bus,
	output ppu_pkg::vram_data_t spr_lo,
	output ppu_pkg::vram_data_t spr_hi,
	output logic spr_xflip,
	output logic spr_load,
	output logic spr_done
);

	typedef enum logic [1:0] {
		SP_IDLE,
		SP_LO,
		SP_HI
	} sp_state_t;

	sp_state_t state;
	logic active;
	logic full;
	logic pend;
	logic got;
	logic take;
	ppu_pkg::spr_entry_t entry;
	ppu_pkg::vram_addr_t row_addr;

	assign spr_ready = active && !full;
	assign take = spr_valid && spr_ready;

	// an entry being offered right now already counts as the head, so a sprite
	// that follows another at the same x is seen before the next pixel leaves.
	assign spr_pending = full || take;
	assign head_x = full ? entry.x : spr_entry.x;

	assign row_addr = ppu_pkg::vram_addr_t'(entry.tile) * ppu_pkg::vram_addr_t'(ppu_pkg::TILE_BYTES)
		+ ppu_pkg::vram_addr_t'({entry.row, 1'b0});
	assign bus.addr = (state == SP_HI) ? row_addr + 1'b1 : row_addr;
	assign bus.req_valid = (state != SP_IDLE) && !pend;
	assign got = bus.rvalid && pend;

	assign spr_done = spr_load;

	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			state <= SP_IDLE;
			active <= 1'b0;
			full <= 1'b0;
			pend <= 1'b0;
			spr_load <= 1'b0;
		end else begin
			spr_load <= 1'b0;
			if (line_start) begin
				state <= SP_IDLE;
				active <= 1'b1;
				full <= 1'b0;
				pend <= 1'b0;
			end else begin
				if (got) begin
					pend <= 1'b0;
				end else if (bus.req_valid && bus.req_ready) begin
					pend <= 1'b1;
				end
				case (state)
					SP_IDLE: begin
						if (spr_go && spr_pending) begin
							state <= SP_LO;
						end
					end
					SP_LO: begin
						if (got) begin
							state <= SP_HI;
						end
					end
					default: begin
						if (got) begin
							state <= SP_IDLE;
							full <= 1'b0;
							spr_load <= 1'b1;
						end
					end
				endcase
			end
			if (take) begin
				full <= 1'b1;
			end
		end
	end

	always_ff @(posedge clkpipe) begin
		if (take) begin
			entry <= spr_entry;
		end
		if (got && state == SP_LO) begin
			spr_lo <= bus.rdata;
		end
		if (got && state == SP_HI) begin
			spr_hi <= bus.rdata;
			spr_xflip <= entry.xflip;
		end
	end

endmodule

/* bg_fetcher.sv */
module bg_fetcher #(
	parameter int LINE_PIXELS = 160
) (
	input logic clkpipe,
	input logic arst_n,
	input logic fetch_req,
	input logic [2:0] line_row,
	input logic line_start,
	vram_bus_if.requester bus,
	output ppu_pkg::vram_data_t bg_lo,
	output ppu_pkg::vram_data_t bg_hi,
	output logic bg_done
);

	localparam int GROUPS = LINE_PIXELS / 8;

	typedef enum logic [1:0] {
		BG_IDLE,
		BG_MAP,
		BG_LO,
		BG_HI
	} bg_state_t;

	bg_state_t state;
	logic pend;
	logic got;
	logic [4:0] group;
	logic [2:0] row;
	ppu_pkg::vram_data_t tile;
	ppu_pkg::vram_addr_t plane_addr;

	assign plane_addr = ppu_pkg::vram_addr_t'(tile) * ppu_pkg::vram_addr_t'(ppu_pkg::TILE_BYTES)
		+ ppu_pkg::vram_addr_t'({row, 1'b0});

	always_comb begin
		case (state)
			BG_MAP: bus.addr = ppu_pkg::MAP_BASE + ppu_pkg::vram_addr_t'(group);
			BG_HI: bus.addr = plane_addr + 1'b1;
			default: bus.addr = plane_addr;
		endcase
	end

	assign bus.req_valid = (state != BG_IDLE) && !pend;
	assign got = bus.rvalid && pend;

	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			state <= BG_IDLE;
			pend <= 1'b0;
			group <= '0;
			bg_done <= 1'b0;
		end else begin
			bg_done <= 1'b0;
			if (line_start) begin
				state <= BG_IDLE;
				pend <= 1'b0;
				group <= '0;
			end else begin
				if (got) begin
					pend <= 1'b0;
				end else if (bus.req_valid && bus.req_ready) begin
					pend <= 1'b1;
				end
				case (state)
					BG_IDLE: begin
						if (fetch_req) begin
							state <= BG_MAP;
						end
					end
					BG_MAP: begin
						if (got) begin
							state <= BG_LO;
						end
					end
					BG_LO: begin
						if (got) begin
							state <= BG_HI;
						end
					end
					BG_HI: begin
						if (got) begin
							state <= BG_IDLE;
							bg_done <= 1'b1;
							group <= (group == 5'(GROUPS - 1)) ? '0 : group + 1'b1;
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clkpipe) begin
		if (line_start) begin
			row <= line_row;
		end
		if (got) begin
			case (state)
				BG_MAP: tile <= bus.rdata;
				BG_LO: bg_lo <= bus.rdata;
				BG_HI: bg_hi <= bus.rdata;
				default: ;
			endcase
		end
	end

endmodule

/* vram_arbiter.sv */
module vram_arbiter (
	input logic clkpipe,
	input logic arst_n,
	vram_bus_if.arbiter spr_bus,
	vram_bus_if.arbiter bg_bus,
	output ppu_pkg::vram_addr_t raddr,
	input ppu_pkg::vram_data_t rdata
);

	logic spr_gnt;
	logic bg_gnt;
	logic spr_s1;
	logic bg_s1;
	logic spr_s2;
	logic bg_s2;

	// sprite reads stall the pixel stream, so they always win.
	assign spr_bus.req_ready = 1'b1;
	assign bg_bus.req_ready = !spr_bus.req_valid;

	assign spr_gnt = spr_bus.req_valid;
	assign bg_gnt = bg_bus.req_valid && !spr_bus.req_valid;

	always_ff @(posedge clkpipe) begin
		if (spr_gnt) begin
			raddr <= spr_bus.addr;
		end else if (bg_gnt) begin
			raddr <= bg_bus.addr;
		end
	end

	// stage one follows the registered address, stage two the RAM output.
	always_ff @(posedge clkpipe or negedge arst_n) begin
		if (!arst_n) begin
			spr_s1 <= 1'b0;
			bg_s1 <= 1'b0;
			spr_s2 <= 1'b0;
			bg_s2 <= 1'b0;
		end else begin
			spr_s1 <= spr_gnt;
			bg_s1 <= bg_gnt;
			spr_s2 <= spr_s1;
			bg_s2 <= bg_s1;
		end
	end

	assign spr_bus.rdata = rdata;
	assign spr_bus.rvalid = spr_s2;
	assign bg_bus.rdata = rdata;
	assign bg_bus.rvalid = bg_s2;

endmodule

/* vram.sv */
module vram (
	input logic clkpipe,
	input logic we,
	input ppu_pkg::vram_addr_t waddr,
	input ppu_pkg::vram_data_t wdata,
	input ppu_pkg::vram_addr_t raddr,
	output ppu_pkg::vram_data_t rdata
);

	ppu_pkg::vram_data_t mem [0:(1 << $bits(ppu_pkg::vram_addr_t)) - 1];

	// the write port is only driven between lines, so it never races a read.
	always_ff @(posedge clkpipe) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	always_ff @(posedge clkpipe) begin
		rdata <= mem[raddr];
	end

endmodule

/* vram_bus_if.sv */
interface vram_bus_if;

	logic req_valid;
	logic req_ready;
	ppu_pkg::vram_addr_t addr;
	ppu_pkg::vram_data_t rdata;
	logic rvalid;

	modport requester (
		output req_valid,
		output addr,
		input req_ready,
		input rdata,
		input rvalid
	);

	modport arbiter (
		input req_valid,
		input addr,
		output req_ready,
		output rdata,
		output rvalid
	);

endinterface

/* ppu_pkg.sv */
package ppu_pkg;

	// byte address into the 8 KiB video RAM.
	typedef logic [12:0] vram_addr_t;

	typedef logic [7:0] vram_data_t;

	// one sprite for the current line, with its tile row already resolved.
	typedef struct packed {
		logic [7:0] x;
		logic [7:0] tile;
		logic [2:0] row;
		logic xflip;
	} spr_entry_t;

	// the background map sits above the tile data, one byte per group of eight pixels.
	localparam vram_addr_t MAP_BASE = 13'd6144;

	// two bitplane bytes for each of the eight rows of a tile.
	localparam int TILE_BYTES = 16;

endpackage
